//--- hdl/pixel_types_pkg.sv
package pixel_types_pkg;

	// One colour sample of one channel.
	typedef logic [15:0] channel_t;

	// Red sits in the low word, blue in the high word.
	typedef struct packed {
		channel_t blue;
		channel_t green;
		channel_t red;
	} pixel_t;

	// Row in the upper five bits, column in the lower five.
	typedef logic [9:0] pixel_index_t;

	// Bits 11:10 select the channel, bits 9:0 the pixel.
	typedef logic [15:0] mem_addr_t;

	typedef enum logic [1:0] {
		CH_RED   = 2'b00,
		CH_GREEN = 2'b01,
		CH_BLUE  = 2'b10,
		CH_NONE  = 2'b11
	} channel_sel_t;

	// Luma weights, scaled so that they sum to 256.
	localparam int unsigned LUMA_R = 77;
	localparam int unsigned LUMA_G = 150;
	localparam int unsigned LUMA_B = 29;

endpackage

//--- hdl/stats_stream_pkg.sv
package stats_stream_pkg;

	import pixel_types_pkg::*;

	// A run of count consecutive pixels starting at first; count is 1 to 1024.
	typedef struct packed {
		pixel_index_t first;
		logic [10:0]  count;
	} scan_cmd_t;

	typedef struct packed {
		logic         valid;
		pixel_index_t index;
	} pixel_tag_t;

	typedef struct packed {
		pixel_index_t index;
		channel_t     luma;
		channel_t     chroma;
		logic         grey;
	} pixel_stats_t;

	typedef enum logic {SCAN_IDLE, SCAN_RUN} scan_state_t;

endpackage

//--- hdl/local_mem_pixel.sv
`timescale 1ns/1ps

module local_mem_pixel
	import pixel_types_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  mem_addr_t read_pixel_addr,
	input  logic      read_pixel_signal,
	input  mem_addr_t write_pixel_addr,
	input  channel_t  write_pixel_data,
	input  logic      write_pixel_signal,
	output pixel_t    read_pixel_data
);

	pixel_t       mem [32][32];
	channel_sel_t write_sel;
	logic [4:0]   write_row;
	logic [4:0]   write_col;
	logic [4:0]   read_row;
	logic [4:0]   read_col;

	assign write_sel = channel_sel_t'(write_pixel_addr[11:10]);
	assign write_row = write_pixel_addr[9:5];
	assign write_col = write_pixel_addr[4:0];
	assign read_row  = read_pixel_addr[9:5];
	assign read_col  = read_pixel_addr[4:0];

	// A write replaces a single channel; the other two keep their value.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			for (int r = 0; r < 32; r++)
			begin
				for (int c = 0; c < 32; c++)
				begin
					mem[r][c] <= '0;
				end
			end
		end
		else if (write_pixel_signal)
		begin
			case (write_sel)
				CH_RED:
				begin
					mem[write_row][write_col].red <= write_pixel_data;
				end
				CH_GREEN:
				begin
					mem[write_row][write_col].green <= write_pixel_data;
				end
				CH_BLUE:
				begin
					mem[write_row][write_col].blue <= write_pixel_data;
				end
				default:
				begin
					// No channel behind this select, so nothing is stored.
				end
			endcase
		end
	end

	// The whole pixel comes back in the same cycle as the address.
	always_comb
	begin
		if (read_pixel_signal)
		begin
			read_pixel_data = mem[read_row][read_col];
		end
		else
		begin
			read_pixel_data = '0;
		end
	end

endmodule

//--- hdl/frame_scan.sv
`timescale 1ns/1ps

module frame_scan
	import pixel_types_pkg::*, stats_stream_pkg::*;
#(
	parameter int CREDITS = 4
)
(
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  scan_cmd_t  scan_cmd,
	input  logic       credit_return,
	output logic       busy,
	output logic       read_pixel_signal,
	output mem_addr_t  read_pixel_addr,
	output pixel_tag_t issue_tag
);

	scan_state_t  state;
	pixel_index_t cur_index;
	logic [10:0]  remaining;
	logic [3:0]   credits;
	logic         issue;

	assign busy  = (state == SCAN_RUN);
	assign issue = busy && (credits != 4'd0);

	assign read_pixel_signal = issue;
	assign read_pixel_addr   = {6'd0, cur_index};
	assign issue_tag.valid   = issue;
	assign issue_tag.index   = cur_index;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= SCAN_IDLE;
			cur_index <= '0;
			remaining <= '0;
		end
		else if (state == SCAN_IDLE)
		begin
			if (start)
			begin
				state     <= SCAN_RUN;
				cur_index <= scan_cmd.first;
				remaining <= scan_cmd.count;
			end
		end
		else if (issue)
		begin
			// The index is ten bits wide, so it wraps from 1023 to 0 by itself.
			cur_index <= cur_index + 10'd1;
			remaining <= remaining - 11'd1;
			if (remaining == 11'd1)
			begin
				state <= SCAN_IDLE;
			end
		end
	end

	// An issue and a return in the same cycle leave the count unchanged.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			credits <= 4'(CREDITS);
		end
		else if (credit_return && !issue)
		begin
			credits <= credits + 4'd1;
		end
		else if (issue && !credit_return)
		begin
			credits <= credits - 4'd1;
		end
	end

	// The consumer cannot hold more records than it was granted.
	assert property (@(posedge clk) disable iff (rst) credits <= 4'(CREDITS));
	assert property (@(posedge clk) disable iff (rst)
		credit_return |-> (credits != 4'(CREDITS)));

endmodule

//--- hdl/luma_unit.sv
`timescale 1ns/1ps

module luma_unit
	import pixel_types_pkg::*, stats_stream_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  pixel_t     pixel_in,
	input  pixel_tag_t tag_in,
	output channel_t   luma,
	output pixel_tag_t tag_out
);

	logic [23:0] prod_r;
	logic [23:0] prod_g;
	logic [23:0] prod_b;
	logic [23:0] weighted_sum;
	pixel_tag_t  tag_mid;

	// Weights sum to 256, so the sum never exceeds 24 bits.
	assign weighted_sum = prod_r + prod_g + prod_b;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tag_mid <= '0;
			tag_out <= '0;
		end
		else
		begin
			tag_mid <= tag_in;
			tag_out <= tag_mid;
		end
	end

	always_ff @(posedge clk)
	begin
		prod_r <= pixel_in.red * 8'(LUMA_R);
		prod_g <= pixel_in.green * 8'(LUMA_G);
		prod_b <= pixel_in.blue * 8'(LUMA_B);
	end

	// Dropping the low byte divides by 256 and rounds down.
	always_ff @(posedge clk)
	begin
		luma <= weighted_sum[23:8];
	end

endmodule

//--- hdl/chroma_unit.sv
`timescale 1ns/1ps

module chroma_unit
	import pixel_types_pkg::*, stats_stream_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  pixel_t     pixel_in,
	input  pixel_tag_t tag_in,
	output channel_t   chroma,
	output pixel_tag_t tag_out
);

	channel_t   max_rg;
	channel_t   min_rg;
	channel_t   max_ch;
	channel_t   min_ch;
	pixel_tag_t tag_mid;

	always_comb
	begin
		max_rg = (pixel_in.red > pixel_in.green) ? pixel_in.red : pixel_in.green;
		min_rg = (pixel_in.red < pixel_in.green) ? pixel_in.red : pixel_in.green;
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			tag_mid <= '0;
			tag_out <= '0;
		end
		else
		begin
			tag_mid <= tag_in;
			tag_out <= tag_mid;
		end
	end

	// Stage one keeps the extremes, stage two their spread.
	always_ff @(posedge clk)
	begin
		max_ch <= (max_rg > pixel_in.blue) ? max_rg : pixel_in.blue;
		min_ch <= (min_rg < pixel_in.blue) ? min_rg : pixel_in.blue;
	end

	always_ff @(posedge clk)
	begin
		chroma <= max_ch - min_ch;
	end

endmodule

//--- hdl/pixel_stats_merge.sv
`timescale 1ns/1ps

module pixel_stats_merge
	import pixel_types_pkg::*, stats_stream_pkg::*;
#(
	parameter channel_t GREY_THRESHOLD = 16'd256
)
(
	input  logic         clk,
	input  logic         rst,
	input  channel_t     luma,
	input  pixel_tag_t   luma_tag,
	input  channel_t     chroma,
	input  pixel_tag_t   chroma_tag,
	output logic         out_valid,
	output pixel_stats_t out_stats
);

	pixel_stats_t record;
	logic         is_grey;

	// A pixel counts as grey when its colour spread stays at or below the threshold.
	assign is_grey = (chroma <= GREY_THRESHOLD);

	always_comb
	begin
		record.index  = luma_tag.index;
		record.luma   = luma;
		record.chroma = chroma;
		record.grey   = is_grey;
	end

	// One record per valid tag; out_valid lasts a single cycle.
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= luma_tag.valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (luma_tag.valid)
		begin
			out_stats <= record;
		end
	end

	// Both pipelines have the same depth, so their tags must match.
	assert property (@(posedge clk) disable iff (rst) luma_tag == chroma_tag);

endmodule

//--- hdl/pixel_stats_top.sv
`timescale 1ns/1ps

module pixel_stats_top
	import pixel_types_pkg::*, stats_stream_pkg::*;
#(
	parameter int       CREDITS        = 4,
	parameter channel_t GREY_THRESHOLD = 16'd256
)
(
	input  logic         clk,
	input  logic         rst,
	input  logic         write_pixel_signal,
	input  mem_addr_t    write_pixel_addr,
	input  channel_t     write_pixel_data,
	input  logic         start,
	input  scan_cmd_t    scan_cmd,
	input  logic         credit_return,
	output logic         busy,
	output logic         out_valid,
	output pixel_stats_t out_stats
);

	logic       read_pixel_signal;
	mem_addr_t  read_pixel_addr;
	pixel_t     read_pixel_data;
	pixel_tag_t issue_tag;
	channel_t   luma;
	pixel_tag_t luma_tag;
	channel_t   chroma;
	pixel_tag_t chroma_tag;

	local_mem_pixel u_mem (
		.clk(clk),
		.rst(rst),
		.read_pixel_addr(read_pixel_addr),
		.read_pixel_signal(read_pixel_signal),
		.write_pixel_addr(write_pixel_addr),
		.write_pixel_data(write_pixel_data),
		.write_pixel_signal(write_pixel_signal),
		.read_pixel_data(read_pixel_data)
	);

	frame_scan #(.CREDITS(CREDITS)) u_scan (
		.clk(clk),
		.rst(rst),
		.start(start),
		.scan_cmd(scan_cmd),
		.credit_return(credit_return),
		.busy(busy),
		.read_pixel_signal(read_pixel_signal),
		.read_pixel_addr(read_pixel_addr),
		.issue_tag(issue_tag)
	);

	luma_unit u_luma (
		.clk(clk),
		.rst(rst),
		.pixel_in(read_pixel_data),
		.tag_in(issue_tag),
		.luma(luma),
		.tag_out(luma_tag)
	);

	chroma_unit u_chroma (
		.clk(clk),
		.rst(rst),
		.pixel_in(read_pixel_data),
		.tag_in(issue_tag),
		.chroma(chroma),
		.tag_out(chroma_tag)
	);

	pixel_stats_merge #(.GREY_THRESHOLD(GREY_THRESHOLD)) u_merge (
		.clk(clk),
		.rst(rst),
		.luma(luma),
		.luma_tag(luma_tag),
		.chroma(chroma),
		.chroma_tag(chroma_tag),
		.out_valid(out_valid),
		.out_stats(out_stats)
	);

	// The scanner reads the memory without arbitration, so the host must stay quiet.
	assert property (@(posedge clk) disable iff (rst) !(write_pixel_signal && busy));

endmodule

//--- tb/pixel_stats_tb.sv
`timescale 1ns/1ps

module pixel_stats_tb
	import pixel_types_pkg::*, stats_stream_pkg::*;
();

	localparam int CREDITS = 4;

	// One write or scan line of the cases file, in file order.
	typedef struct packed {
		logic [7:0]  kind;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] c;
		logic [15:0] d;
	} case_line_t;

	logic         clk;
	logic         rst;
	logic         write_pixel_signal;
	mem_addr_t    write_pixel_addr;
	channel_t     write_pixel_data;
	logic         start;
	scan_cmd_t    scan_cmd;
	logic         credit_return = 1'b0;
	logic         busy;
	logic         out_valid;
	pixel_stats_t out_stats;

	case_line_t   ops_q[$];
	pixel_stats_t exp_q[$];
	int unsigned  due_q[$];
	int unsigned  lcg_state = 89822;
	int unsigned  cycle_count = 0;
	int unsigned  cycle_limit = 0;
	int           outstanding = 0;
	int           quiet_cycles = 0;
	logic         ops_done = 1'b0;

	pixel_stats_top UUT (
		.clk(clk),
		.rst(rst),
		.write_pixel_signal(write_pixel_signal),
		.write_pixel_addr(write_pixel_addr),
		.write_pixel_data(write_pixel_data),
		.start(start),
		.scan_cmd(scan_cmd),
		.credit_return(credit_return),
		.busy(busy),
		.out_valid(out_valid),
		.out_stats(out_stats)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic int unsigned next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	task automatic report_failure(string what);
		$display("%s", what);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_value(string name, logic [15:0] got, logic [15:0] want);
		assert (got === want)
		else
		begin
			report_failure($sformatf("CHECK FAILED %s: got 0x%h, expected 0x%h",
				name, got, want));
		end
	endtask

	task automatic read_cases();
		int           fd;
		int           code;
		int           ch;
		int           write_lines;
		logic [7:0]   kind;
		logic [15:0]  a;
		logic [15:0]  b;
		logic [15:0]  c;
		logic [15:0]  d;
		pixel_stats_t rec;
		write_lines = 0;
		fd = $fopen("tb/pixel_stats_cases.txt", "r");
		assert (fd != 0)
		else
		begin
			report_failure("Cannot open tb/pixel_stats_cases.txt for reading.");
		end
		code = $fscanf(fd, " %c", kind);
		while (code == 1)
		begin
			a = '0;
			b = '0;
			c = '0;
			d = '0;
			if (kind == "#")
			begin
				// A comment runs to the end of its line.
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
				begin
					ch = $fgetc(fd);
				end
			end
			else if (kind == "W" || kind == "E")
			begin
				code = $fscanf(fd, "%h %h %h %h", a, b, c, d);
				assert (code == 4)
				else
				begin
					report_failure("A W or E line in the cases file lacks a field.");
				end
				if (kind == "W")
				begin
					ops_q.push_back({kind, a, b, c, d});
					write_lines++;
				end
				else
				begin
					rec.index  = a[9:0];
					rec.luma   = b;
					rec.chroma = c;
					rec.grey   = d[0];
					exp_q.push_back(rec);
				end
			end
			else if (kind == "S")
			begin
				code = $fscanf(fd, "%h %h", a, b);
				assert (code == 2)
				else
				begin
					report_failure("An S line in the cases file lacks a field.");
				end
				ops_q.push_back({kind, a, b, c, d});
			end
			else
			begin
				report_failure($sformatf("Unknown line kind '%c' in the cases file.", kind));
			end
			code = $fscanf(fd, " %c", kind);
		end
		$fclose(fd);
		cycle_limit = 40 * (write_lines + exp_q.size()) + 200;
	endtask

	task automatic wait_idle();
		while (busy)
		begin
			@(negedge clk);
		end
	endtask

	task automatic write_channel(channel_sel_t sel, pixel_index_t index, channel_t data);
		write_pixel_signal = 1'b1;
		write_pixel_addr   = {4'd0, sel, index};
		write_pixel_data   = data;
		@(negedge clk);
	endtask

	task automatic write_pixel(case_line_t op);
		wait_idle();
		write_channel(CH_RED, op.a[9:0], op.b);
		write_channel(CH_GREEN, op.a[9:0], op.c);
		write_channel(CH_BLUE, op.a[9:0], op.d);
		write_pixel_signal = 1'b0;
	endtask

	task automatic start_scan(case_line_t op);
		wait_idle();
		scan_cmd.first = op.a[9:0];
		scan_cmd.count = op.b[10:0];
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		// The command was taken at the edge just passed, so the scan runs now.
		check_value("busy", 16'(busy), 16'd1);
	endtask

	initial
	begin
		case_line_t op;
		rst                = 1'b1;
		write_pixel_signal = 1'b0;
		write_pixel_addr   = '0;
		write_pixel_data   = '0;
		start              = 1'b0;
		scan_cmd           = '0;
		read_cases();
		repeat (5) @(negedge clk);
		rst = 1'b0;
		while (ops_q.size() != 0)
		begin
			op = ops_q.pop_front();
			if (op.kind == "W")
			begin
				write_pixel(op);
			end
			else
			begin
				start_scan(op);
			end
		end
		ops_done = 1'b1;
	end

	// The consumer checks each record and hands its credit back after a random delay.
	always @(negedge clk)
	begin
		pixel_stats_t expected;
		int unsigned  delay;
		cycle_count++;
		assert (cycle_count < cycle_limit)
		else
		begin
			report_failure($sformatf("Timeout after %0d cycles, %0d records never arrived.",
				cycle_count, exp_q.size()));
		end
		credit_return = 1'b0;
		if (!rst)
		begin
			if (out_valid)
			begin
				assert (exp_q.size() != 0)
				else
				begin
					report_failure($sformatf("An extra record for pixel 0x%h arrived.",
						out_stats.index));
				end
				expected = exp_q.pop_front();
				check_value("out_stats.index", 16'(out_stats.index), 16'(expected.index));
				check_value("out_stats.luma", out_stats.luma, expected.luma);
				check_value("out_stats.chroma", out_stats.chroma, expected.chroma);
				check_value("out_stats.grey", 16'(out_stats.grey), 16'(expected.grey));
				outstanding++;
				assert (outstanding <= CREDITS)
				else
				begin
					report_failure("More records are outstanding than the consumer has credits.");
				end
				delay = next_random() % 7;
				due_q.push_back(cycle_count + delay);
			end
			if (due_q.size() != 0 && due_q[0] <= cycle_count)
			begin
				void'(due_q.pop_front());
				credit_return = 1'b1;
				outstanding--;
			end
			if (ops_done && exp_q.size() == 0 && !out_valid)
			begin
				quiet_cycles++;
			end
			if (quiet_cycles == 10)
			begin
				$display("Testbench passed");
				$finish;
			end
		end
	end

endmodule

//--- tb/pixel_stats_cases.txt
# W index red green blue | S first count | E index luma chroma grey
# All fields are hex; E lines list the records in the order they leave the DUT.
S 000 3
E 000 0000 0000 1
E 001 0000 0000 1
E 002 0000 0000 1
W 005 0100 0200 0300
W 006 1000 1000 1000
W 007 FFFF FFFF FFFF
W 008 0000 0100 0000
W 009 0000 0000 0101
W 00A 1234 5678 9ABC
W 2A5 0300 0200 0100
S 005 6
E 005 01D0 0200 0
E 006 1000 0000 1
E 007 FFFF 0000 1
E 008 0096 0100 1
E 009 001D 0101 0
E 00A 49AB 8888 0
W 005 0100 0A00 0300
S 005 1
E 005 0680 0900 0
W 3FE 8000 0000 0000
W 3FF 0010 0020 0030
S 3FE 5
E 3FE 2680 8000 0
E 3FF 001D 0020 1
E 000 0000 0000 1
E 001 0000 0000 1
E 002 0000 0000 1
S 2A5 1
E 2A5 0230 0200 0

//--- vlog.f
hdl/pixel_types_pkg.sv
hdl/stats_stream_pkg.sv
hdl/local_mem_pixel.sv
hdl/frame_scan.sv
hdl/luma_unit.sv
hdl/chroma_unit.sv
hdl/pixel_stats_merge.sv
hdl/pixel_stats_top.sv
tb/pixel_stats_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status gives pass or fail.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module pixel_stats_tb -f vlog.f -o pixel_stats_sim \
	&& ./obj_dir/pixel_stats_sim \
	|| exit 1
